// File: tests/fetch_tests.txt
# stall valid redirect branch_pc target_pc expected_fetch_pc expected_predicted (hex)
# one line per cycle after reset; the inputs act at the edge that ends the cycle.
0 0 0 00000000 00000000 00000000 0
0 0 0 00000000 00000000 00000004 0
0 0 0 00000000 00000000 00000008 0
0 1 1 0000000c 00000040 0000000c 0
0 0 1 00000000 0000000c 00000040 0
0 0 0 00000000 00000000 0000000c 1
0 0 0 00000000 00000000 00000040 0
1 0 0 00000000 00000000 00000044 0
1 1 0 00000044 00000080 00000044 0
1 0 1 00000000 00000100 00000044 1
0 1 0 00000200 00000300 00000100 0
0 1 0 00000210 00000310 00000104 0
0 1 0 00000220 00000320 00000108 0
0 1 0 00000230 00000330 0000010c 0
0 1 0 00000240 00000340 00000110 0
0 1 0 00000250 00000350 00000114 0
0 1 0 00000260 00000360 00000118 0
0 0 1 00000000 0000000c 0000011c 0
0 0 1 00000000 00000044 0000000c 0
0 0 0 00000000 00000000 00000044 1
0 0 1 00000000 00000260 00000080 0
0 0 0 00000000 00000000 00000260 1
0 1 1 00000200 00000400 00000360 0
0 0 1 00000000 00000200 00000400 0
0 0 0 00000000 00000000 00000200 1
0 0 1 00000000 00000044 00000400 0
0 0 0 00000000 00000000 00000044 0
0 1 0 00000210 00000310 00000048 0
0 1 0 00000270 00000370 0000004c 0
0 0 1 00000000 00000210 00000050 0
0 0 0 00000000 00000000 00000210 1
0 0 1 00000000 00000270 00000310 0
0 0 0 00000000 00000000 00000270 1
0 0 0 00000000 00000000 00000370 0

// File: project.f
logic/fetch_pkg.sv
logic/btb_victim_select.sv
logic/btb_table.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
tests/tb_clock_gen.sv
tests/fetch_sva.sv
tests/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the fetch stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module fetch_tb -f project.f --Mdir obj_dir -o fetch_sim

./obj_dir/fetch_sim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
else
    exit 1
fi

// File: tests/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb;
    import fetch_pkg::*;

    localparam int RESET_CYCLES = 3;
    localparam int CLK_PERIOD   = 10;
    localparam int MARGIN_NS    = 100;

    // one cycle of stimulus with the outputs expected during that cycle.
    typedef struct packed
    {
        logic                 stall;
        resolve_t             resolve;
        logic [ADDR_BITS-1:0] exp_pc;
        logic                 exp_predicted;
    } test_vec_t;

    logic                 clk;
    logic                 reset_n;
    logic                 stall;
    resolve_t             resolve;
    logic [ADDR_BITS-1:0] fetch_pc;
    logic                 fetch_valid;
    logic                 predicted;

    test_vec_t vectors[$];
    bit        loaded;

    tb_clock_gen tb_clock_gen_inst
    (
        .o_clk         (clk),
        .o_reset_n     (reset_n)
    );

    fetch_top fetch_top_inst
    (
        .i_clk         (clk),
        .i_reset_n     (reset_n),
        .i_stall       (stall),
        .i_resolve     (resolve),
        .o_fetch_pc    (fetch_pc),
        .o_fetch_valid (fetch_valid),
        .o_predicted   (predicted)
    );

    bind fetch_ctrl fetch_sva fetch_sva_inst
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_stall       (i_stall),
        .i_resolve     (i_resolve),
        .i_predict     (i_predict),
        .o_fetch_pc    (o_fetch_pc),
        .o_fetch_valid (o_fetch_valid)
    );

    // ****************************************
    // helpers
    // ****************************************

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("[FAIL] time %0d ns: %s is %h, expected %h", $time, what, got, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          count;
        string       line;
        logic [31:0] f_stall;
        logic [31:0] f_valid;
        logic [31:0] f_redirect;
        logic [31:0] f_branch;
        logic [31:0] f_target;
        logic [31:0] f_pc;
        logic [31:0] f_pred;
        test_vec_t   vec;
        fd = $fopen("tests/fetch_tests.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the test data file tests/fetch_tests.txt");
            $display("TEST RESULT: FAIL");
            $fatal(1, "missing test data");
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line.getc(0) == "#")
            begin
                continue; // blank lines and column notes.
            end
            count = $sscanf(line, "%h %h %h %h %h %h %h",
                            f_stall, f_valid, f_redirect, f_branch, f_target, f_pc, f_pred);
            if (count != 7)
            begin
                $display("test data line has %0d fields instead of 7: %s", count, line);
                $display("TEST RESULT: FAIL");
                $fatal(1, "bad test data");
            end
            vec.stall             = f_stall[0];
            vec.resolve.valid     = f_valid[0];
            vec.resolve.redirect  = f_redirect[0];
            vec.resolve.branch_pc = f_branch;
            vec.resolve.target_pc = f_target;
            vec.exp_pc            = f_pc;
            vec.exp_predicted     = f_pred[0];
            vectors.push_back(vec);
        end
        $fclose(fd);
    endtask

    // ****************************************
    // stimulus and checks
    // ****************************************

    initial
    begin : run
        test_vec_t vec;
        stall   = 1'b0;
        resolve = '0;
        load_vectors();
        loaded = 1'b1;
        @(posedge reset_n); // released 1 ns after an edge, like every input.
        for (int n = 0; n < vectors.size(); n++)
        begin
            vec     = vectors[n];
            stall   = vec.stall;
            resolve = vec.resolve;
            #8; // just before the next edge.
            check_value("o_fetch_pc", fetch_pc, vec.exp_pc);
            check_value("o_predicted", 32'(predicted), 32'(vec.exp_predicted));
            check_value("o_fetch_valid", 32'(fetch_valid), 32'(n != 0));
            @(posedge clk);
            #1;
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial
    begin : watchdog
        int limit_ns;
        wait (loaded);
        limit_ns = CLK_PERIOD * (RESET_CYCLES + vectors.size()) + MARGIN_NS;
        #(limit_ns);
        $display("watchdog: the run did not finish within %0d ns", limit_ns);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

// File: tests/fetch_sva.sv
`timescale 1ns/10ps

module fetch_sva
(
    input logic                            i_clk,
    input logic                            i_reset_n,
    input logic                            i_stall,
    input fetch_pkg::resolve_t             i_resolve,
    input fetch_pkg::predict_t             i_predict,
    input logic [fetch_pkg::ADDR_BITS-1:0] o_fetch_pc,
    input logic                            o_fetch_valid
);
    import fetch_pkg::*;

    // nothing is fetched while reset is held.
    a_no_valid_in_reset : assert property (@(posedge i_clk) !i_reset_n |=> !o_fetch_valid)
        else $error("o_fetch_valid was high after a reset cycle");

    a_redirect_target : assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_resolve.redirect |=> (o_fetch_pc == $past(i_resolve.target_pc)))
        else $error("a redirect did not move fetch to its target");

    // ****************************************
    // sequential fetch
    // ****************************************

    a_sequential : assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (!i_resolve.redirect && !i_stall && !i_predict.hit)
        |=> (o_fetch_pc == $past(o_fetch_pc) + ADDR_BITS'(4)))
        else $error("fetch did not advance by four without a hit");

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen
(
    output logic o_clk,
    output logic o_reset_n
);

    initial
    begin
        o_clk = 1'b0;
        forever
        begin
            #5 o_clk = ~o_clk; // 10 ns period.
        end
    end

    // reset is held low over three rising edges and released just after the third.
    initial
    begin
        o_reset_n = 1'b0;
        repeat (3) @(posedge o_clk);
        #1 o_reset_n = 1'b1;
    end

endmodule

// File: logic/fetch_top.sv
`timescale 1ns/10ps

module fetch_top
(
    input  logic                            i_clk,
    input  logic                            i_reset_n,
    input  logic                            i_stall,
    input  fetch_pkg::resolve_t             i_resolve,
    output logic [fetch_pkg::ADDR_BITS-1:0] o_fetch_pc,
    output logic                            o_fetch_valid,
    output logic                            o_predicted
);
    import fetch_pkg::*;

    predict_t                predict;
    btb_hist_t               hist;
    logic [BTB_IDX_BITS-1:0] victim_idx;

    fetch_ctrl fetch_ctrl_inst
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_stall            (i_stall),
        .i_resolve          (i_resolve),
        .i_predict          (predict),
        .o_fetch_pc         (o_fetch_pc),
        .o_fetch_valid      (o_fetch_valid)
    );

    // the buffer looks up the address that the control module holds.
    btb_table btb_table_inst
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_lookup_pc        (o_fetch_pc),
        .i_resolve          (i_resolve),
        .i_victim_idx       (victim_idx),
        .o_predict          (predict),
        .o_hist             (hist)
    );

    btb_victim_select btb_victim_select_inst
    (
        .i_hist             (hist),
        .o_victim_idx       (victim_idx)
    );

    assign o_predicted = predict.hit;

endmodule

// File: logic/fetch_ctrl.sv
`timescale 1ns/10ps

module fetch_ctrl
(
    input  logic                            i_clk,
    input  logic                            i_reset_n,
    input  logic                            i_stall,
    input  fetch_pkg::resolve_t             i_resolve,
    input  fetch_pkg::predict_t             i_predict,
    output logic [fetch_pkg::ADDR_BITS-1:0] o_fetch_pc,
    output logic                            o_fetch_valid
);
    import fetch_pkg::*;

    logic [ADDR_BITS-1:0] pc_q;
    logic [ADDR_BITS-1:0] seq_pc;
    logic [ADDR_BITS-1:0] next_pc;
    logic                 valid_q;

    // ****************************************
    // next address
    // ****************************************

    assign seq_pc = pc_q + ADDR_BITS'(4);

    // a redirect wins even over a stall.
    always_comb
    begin
        if (i_resolve.redirect)
        begin
            next_pc = i_resolve.target_pc;
        end
        else if (i_stall)
        begin
            next_pc = pc_q;
        end
        else if (i_predict.hit)
        begin
            next_pc = i_predict.target;
        end
        else
        begin
            next_pc = seq_pc;
        end
    end

    // ****************************************
    // state
    // ****************************************

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            pc_q    <= RESET_PC;
            valid_q <= 1'b0;
        end
        else
        begin
            pc_q    <= next_pc;
            valid_q <= 1'b1; // stays high until the next reset.
        end
    end

    assign o_fetch_pc    = pc_q;
    assign o_fetch_valid = valid_q;

endmodule

// File: logic/btb_table.sv
`timescale 1ns/10ps

module btb_table
(
    input  logic                               i_clk,
    input  logic                               i_reset_n,
    input  logic [fetch_pkg::ADDR_BITS-1:0]    i_lookup_pc,
    input  fetch_pkg::resolve_t                i_resolve,
    input  logic [fetch_pkg::BTB_IDX_BITS-1:0] i_victim_idx,
    output fetch_pkg::predict_t                o_predict,
    output fetch_pkg::btb_hist_t               o_hist
);
    import fetch_pkg::*;

    logic [ADDR_BITS-1:0]    branch_q [BTB_ENTRIES];
    logic [ADDR_BITS-1:0]    target_q [BTB_ENTRIES];
    btb_hist_t               hist_q;
    logic [BTB_ENTRIES-1:0]  live;

    logic                    look_hit;
    logic [BTB_IDX_BITS-1:0] look_idx;
    logic                    same_hit;
    logic [BTB_IDX_BITS-1:0] same_idx;

    logic [BTB_IDX_BITS-1:0] wr_idx;
    logic                    target_changed;
    logic                    age_others;
    logic [HIST_BITS-1:0]    wr_hist;

    // ****************************************
    // lookup and write match
    // ****************************************

    always_comb
    begin
        for (int i = 0; i < BTB_ENTRIES; i++)
        begin
            live[i] = |hist_q[i]; // an entry lives while its history is nonzero.
        end
    end

    // scanning downward leaves the lowest matching index in place.
    always_comb
    begin
        look_hit = 1'b0;
        look_idx = '0;
        same_hit = 1'b0;
        same_idx = '0;
        for (int i = BTB_ENTRIES - 1; i >= 0; i--)
        begin
            if (live[i] && (branch_q[i] == i_lookup_pc))
            begin
                look_hit = 1'b1;
                look_idx = BTB_IDX_BITS'(i);
            end
            if (live[i] && (branch_q[i] == i_resolve.branch_pc))
            begin
                same_hit = 1'b1;
                same_idx = BTB_IDX_BITS'(i);
            end
        end
    end

    assign o_predict.hit    = look_hit;
    assign o_predict.target = target_q[look_idx];
    assign o_hist           = hist_q;

    // ****************************************
    // write and aging
    // ****************************************

    assign wr_idx         = same_hit ? same_idx : i_victim_idx;
    assign target_changed = target_q[wr_idx] != i_resolve.target_pc;
    assign age_others     = i_resolve.valid & (~same_hit | target_changed);

    // only a live match carries its old history forward.
    assign wr_hist = {1'b1, same_hit ? hist_q[wr_idx][HIST_BITS-1:1] : {(HIST_BITS-1){1'b0}}};

    always_ff @(posedge i_clk)
    begin
        if (i_resolve.valid)
        begin
            branch_q[wr_idx] <= i_resolve.branch_pc;
            target_q[wr_idx] <= i_resolve.target_pc;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            hist_q <= '0;
        end
        else if (i_resolve.valid)
        begin
            for (int i = 0; i < BTB_ENTRIES; i++)
            begin
                if (BTB_IDX_BITS'(i) == wr_idx)
                begin
                    hist_q[i] <= wr_hist;
                end
                else if (age_others)
                begin
                    hist_q[i] <= {1'b0, hist_q[i][HIST_BITS-1:1]}; // lowest bit drops out.
                end
            end
        end
    end

endmodule

// File: logic/btb_victim_select.sv
`timescale 1ns/10ps

module btb_victim_select
(
    input  fetch_pkg::btb_hist_t                i_hist,
    output logic [fetch_pkg::BTB_IDX_BITS-1:0]  o_victim_idx
);
    import fetch_pkg::*;

    localparam int NODES = 2 * BTB_ENTRIES - 1;

    // binary tree kept as a heap, node 0 is the root.
    // leaves sit at BTB_ENTRIES-1 and up, entry 0 first.
    logic [HIST_BITS-1:0]    node_val [NODES];
    logic [BTB_IDX_BITS-1:0] node_idx [NODES];

    genvar i;
    generate
        for (i = 0; i < BTB_ENTRIES; i++)
        begin : g_leaf
            assign node_val[BTB_ENTRIES-1+i] = i_hist[i];
            assign node_idx[BTB_ENTRIES-1+i] = BTB_IDX_BITS'(i);
        end

        for (i = 0; i < BTB_ENTRIES - 1; i++)
        begin : g_node
            logic take_right;

            // the left child covers lower indices, so it keeps a tie.
            assign take_right  = node_val[2*i+2] < node_val[2*i+1];
            assign node_val[i] = take_right ? node_val[2*i+2] : node_val[2*i+1];
            assign node_idx[i] = take_right ? node_idx[2*i+2] : node_idx[2*i+1];
        end
    endgenerate

    assign o_victim_idx = node_idx[0]; // a zero history always ends up here.

endmodule

// File: logic/fetch_pkg.sv
package fetch_pkg;

    // ****************************************
    // sizes
    // ****************************************

    localparam int ADDR_BITS    = 32;
    localparam int BTB_IDX_BITS = 3;
    localparam int BTB_ENTRIES  = 8;
    localparam int HIST_BITS    = BTB_ENTRIES; // one history bit per possible aging step.

    localparam logic [ADDR_BITS-1:0] RESET_PC = 32'h0000_0000;

    // ****************************************
    // shared types
    // ****************************************

    // a branch resolved by the execute stage.
    typedef struct packed
    {
        logic                 valid;    // a taken branch was resolved.
        logic                 redirect; // fetch must jump to target_pc.
        logic [ADDR_BITS-1:0] branch_pc;
        logic [ADDR_BITS-1:0] target_pc;
    } resolve_t;

    // result of a buffer lookup on the current fetch address.
    typedef struct packed
    {
        logic                 hit;
        logic [ADDR_BITS-1:0] target;
    } predict_t;

    // recency history of every buffer entry.
    typedef logic [BTB_ENTRIES-1:0][HIST_BITS-1:0] btb_hist_t;

endpackage
